// ==== Makefile ====
TOP = mcuLogicTb

.PHONY: sim clean

sim:
	verilator --binary --timing -sv -Wno-fatal --top-module $(TOP) -f files.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== coincidenceUnit.sv ====
// coincidence matching of A cable n against B cable n within one clock either way
`timescale 1ns/10ps

module coincidenceUnit #(
   parameter int NumPairs = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [2*NumPairs-1:0] single,       // A side low half, B side high half
   output logic [2*NumPairs-1:0] promptCoinc,  // answer for each cable
   output logic [2*NumPairs-1:0] noCoinc
);

   for (genvar p = 0; p < NumPairs; p++) begin : gPair
      logic [2:0] histA;  // last three singles of A cable p
      logic [2:0] histB;  // last three singles of B cable p

      // newest sample in bit 0
      always_ff @(posedge clk) begin
         if (rst) begin
            histA <= '0;
            histB <= '0;
         end else begin
            histA <= {histA[1:0], single[p]};
            histB <= {histB[1:0], single[p+NumPairs]};
         end
      end

      // middle bit is the single under test
      // partner bits span one clock before to one clock after it
      assign promptCoinc[p] = histA[1] && (histB != '0);
      assign noCoinc[p]     = histA[1] && (histB == '0);
      assign promptCoinc[p+NumPairs] = histB[1] && (histA != '0);
      assign noCoinc[p+NumPairs]     = histB[1] && (histA == '0);
   end

endmodule

// ==== files.f ====
mcuPkg.sv
regBank.sv
linkReceiver.sv
linkTransmitter.sv
coincidenceUnit.sv
mcuLogic.sv
mcuLogicTb.sv

// ==== linkReceiver.sv ====
// cable receiver that flags trigger words and counts idle sequence violations
`timescale 1ns/10ps

module linkReceiver (
   input  logic              clk,
   input  logic              rst,
   input  mcuPkg::rxWord_t   rxWord,   // one word per clock from the cable
   output logic              single,   // trigger word seen on the last edge
   output mcuPkg::errCount_t badIdle   // running count of violations
);
   import mcuPkg::*;

   rxWord_t     prevWord;   // word sampled at the previous edge
   idleCount_t  idleCnt;    // counter value of the last complete frame
   logic [11:0] partCnt;    // counter bits gathered from IDLE0 to IDLE2
   idleCount_t  frameCnt;   // full counter as the IDLE3 word arrives
   logic        isTrig;     // current word is a trigger
   logic        prevTrig;   // previous word was a trigger
   rxWord_t     curType;    // idle type bits of the current word
   rxWord_t     prevType;   // idle type bits of the previous word
   logic        orderBad;   // word out of sequence
   logic        countBad;   // frame counter did not step by one
   logic        badInc;     // violation seen on the last edge

   // word classification and checks
   always_comb begin
      isTrig   = (rxWord & TrigMask) != '0;
      prevTrig = (prevWord & TrigMask) != '0;
      curType  = rxWord & IdleMask;
      prevType = prevWord & IdleMask;  // a trigger never matches an idle type here
      frameCnt = {rxWord[5:4], rxWord[1:0], partCnt};
      orderBad = 1'b0;
      countBad = 1'b0;
      if (!isTrig) begin  // trigger words skip the order check
         case (curType)
            RxIdle0: orderBad = !prevTrig && (prevType != RxIdle3);  // after IDLE3 or a trigger
            RxIdle1: orderBad = prevType != RxIdle0;
            RxIdle2: orderBad = prevType != RxIdle1;
            RxIdle3: begin
               orderBad = prevType != RxIdle2;
               // each frame must carry the previous count plus one
               countBad = frameCnt != idleCount_t'(idleCnt + 16'd1);
            end
            default: orderBad = 1'b1;  // neither idle nor trigger
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         single   <= 1'b0;
         prevWord <= RxIdle3;  // clean stream after reset begins with IDLE0
         idleCnt  <= '0;       // first good frame carries 1
         partCnt  <= '0;
         badInc   <= 1'b0;
         badIdle  <= '0;
      end else begin
         single   <= isTrig;
         prevWord <= rxWord;
         badInc   <= orderBad || countBad;
         if (badInc) begin
            badIdle <= badIdle + 1'b1;  // lands one edge after detection
         end
         // collect counter nibbles
         if (!isTrig) begin
            case (curType)
               RxIdle0: partCnt[3:0]  <= {rxWord[5:4], rxWord[1:0]};
               RxIdle1: partCnt[7:4]  <= {rxWord[5:4], rxWord[1:0]};
               RxIdle2: partCnt[11:8] <= {rxWord[5:4], rxWord[1:0]};
               RxIdle3: idleCnt       <= frameCnt;  // frame complete
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== linkTransmitter.sv ====
// cable transmitter FSM for idle, coincidence answer, special word and test pattern symbols
`timescale 1ns/10ps

module linkTransmitter (
   input  logic             clk,
   input  logic             rst,
   input  logic             promptCoinc,   // partner found within the window
   input  logic             noCoinc,       // no partner found
   input  logic             specialGo,     // start the special word sequence
   input  logic             testEn,        // hold the test pattern on the output
   input  mcuPkg::busData_t specialWord,
   input  mcuPkg::txSym_t   testPatt,
   output mcuPkg::txSym_t   txSym          // registered symbol to the cable
);
   import mcuPkg::*;

   txState_e state;
   txState_e nextState;
   txSym_t   symNext;     // symbol of the current state
   logic     acceptCmd;   // state may be left for an answer or special word

   always_comb begin
      nextState = Idle0;
      symNext   = SymIdle0;
      case (state)
         Idle0: begin
            symNext   = SymIdle0;
            nextState = Idle1;
         end
         Idle1: begin
            symNext   = SymIdle1;
            nextState = Idle2;
         end
         Idle2: begin
            symNext   = SymIdle2;
            nextState = Idle3;
         end
         Idle3: begin
            symNext   = SymIdle3;
            nextState = Idle0;  // rotation restarts
         end
         NoCoinc:     symNext = SymNoCoinc;
         PromptCoinc: symNext = SymPromptCoinc;
         SpecialHdr: begin
            symNext   = SymSpecial;
            nextState = Spec1;
         end
         Spec1: begin
            symNext   = specialWord[15:12];  // most significant nibble first
            nextState = Spec2;
         end
         Spec2: begin
            symNext   = specialWord[11:8];
            nextState = Spec3;
         end
         Spec3: begin
            symNext   = specialWord[7:4];
            nextState = Spec4;
         end
         Spec4:   symNext = specialWord[3:0];
         default: ;  // unused encodings fall back to Idle0
      endcase

      // header and first three nibbles run uninterrupted
      acceptCmd = !(state inside {SpecialHdr, Spec1, Spec2, Spec3});
      if (acceptCmd) begin
         if (specialGo) begin
            nextState = SpecialHdr;
         end else if (promptCoinc) begin
            nextState = PromptCoinc;
         end else if (noCoinc) begin
            nextState = NoCoinc;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= Idle0;
         txSym <= '0;
      end else begin
         state <= nextState;
         // test pattern wins, FSM keeps stepping
         txSym <= testEn ? testPatt : symNext;
      end
   end

endmodule

// ==== mcuLogic.sv ====
// master coincidence unit top level joining register bank, cable links and coincidence unit
`timescale 1ns/10ps

module mcuLogic #(
   parameter int NumPairs = 4  // cable pairs, at most 8
) (
   input  logic                                clk,
   input  logic                                rst,
   // register bus
   input  mcuPkg::busAddr_t                    addr,
   input  mcuPkg::busData_t                    wrData,
   input  logic                                wr,
   input  logic                                strobe,
   output mcuPkg::busData_t                    rdData,
   // cables, A side first then B side
   input  mcuPkg::rxWord_t   [2*NumPairs-1:0]  rxWord,
   output mcuPkg::txSym_t    [2*NumPairs-1:0]  txSym
);
   import mcuPkg::*;

   localparam int NumCables = 2 * NumPairs;

   busData_t                     specialWord;
   txSym_t                       testPatt;
   logic      [NumCables-1:0]    testEn;
   logic                         specialGo;    // shared by all transmitters
   logic      [NumCables-1:0]    single;       // receivers to coincidence unit
   logic      [NumCables-1:0]    promptCoinc;  // coincidence unit to transmitters
   logic      [NumCables-1:0]    noCoinc;
   errCount_t [NumCables-1:0]    badIdle;      // receivers to readback

   regBank #(
      .NumPairs(NumPairs)
   ) u_regBank (
      .clk        (clk),
      .rst        (rst),
      .addr       (addr),
      .wrData     (wrData),
      .wr         (wr),
      .strobe     (strobe),
      .rdData     (rdData),
      .badIdle    (badIdle),
      .specialWord(specialWord),
      .testPatt   (testPatt),
      .testEn     (testEn),
      .specialGo  (specialGo)
   );

   // one receiver and one transmitter per cable
   for (genvar i = 0; i < NumCables; i++) begin : gCable
      linkReceiver u_linkReceiver (
         .clk    (clk),
         .rst    (rst),
         .rxWord (rxWord[i]),
         .single (single[i]),
         .badIdle(badIdle[i])
      );

      linkTransmitter u_linkTransmitter (
         .clk        (clk),
         .rst        (rst),
         .promptCoinc(promptCoinc[i]),
         .noCoinc    (noCoinc[i]),
         .specialGo  (specialGo),
         .testEn     (testEn[i]),
         .specialWord(specialWord),
         .testPatt   (testPatt),
         .txSym      (txSym[i])
      );
   end

   // every pair wired, A cable n against B cable n
   coincidenceUnit #(
      .NumPairs(NumPairs)
   ) u_coincidenceUnit (
      .clk        (clk),
      .rst        (rst),
      .single     (single),
      .promptCoinc(promptCoinc),
      .noCoinc    (noCoinc)
   );

endmodule

// ==== mcuLogicTb.sv ====
// directed testbench for the master coincidence unit with idle stream generator and bus tasks
`timescale 1ns/10ps

module mcuLogicTb;
   import mcuPkg::*;

   localparam int NumPairs  = 4;
   localparam int NumCables = 2 * NumPairs;  // A side 0..3, B side 4..7

   logic                    clk;
   logic                    rst;
   busAddr_t                addr;
   busData_t                wrData;
   logic                    wr;
   logic                    strobe;
   busData_t                rdData;
   rxWord_t [NumCables-1:0] rxWord = '0;
   txSym_t  [NumCables-1:0] txSym;

   logic [1:0] phase = 2'd0;     // idle index driven at the coming edge
   idleCount_t frameNo = 16'd1;  // counter carried by the current frame
   int         cyc = 0;          // generator edge count
   int         ovrCyc [NumCables];   // edge where a cable sends ovrWord instead
   rxWord_t    ovrWord [NumCables];
   integer     seed = 32'h7e99;
   int         errors = 0;

   mcuLogic #(
      .NumPairs(NumPairs)
   ) u_mcuLogic (
      .clk   (clk),
      .rst   (rst),
      .addr  (addr),
      .wrData(wrData),
      .wr    (wr),
      .strobe(strobe),
      .rdData(rdData),
      .rxWord(rxWord),
      .txSym (txSym)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   // idle word k: 01 in bits 7:6, k in 3:2, counter nibble k in 5:4 and 1:0
   function automatic rxWord_t idleWord(input logic [1:0] k, input idleCount_t cnt);
      logic [3:0] nib;
      nib = cnt[4*k +: 4];
      return {2'b01, nib[3:2], k, nib[1:0]};
   endfunction

   // idle symbol rotation, zero for anything else
   function automatic txSym_t successor(input txSym_t s);
      case (s)
         SymIdle0: return SymIdle1;
         SymIdle1: return SymIdle2;
         SymIdle2: return SymIdle3;
         SymIdle3: return SymIdle0;
         default:  return 4'b0000;
      endcase
   endfunction

   // clean stream on every cable, one override word per cable when scheduled
   always @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NumCables; i++) rxWord[i] <= idleWord(2'd0, 16'd1);
         phase   <= 2'd1;   // IDLE0 of frame 1 already on the wires
         frameNo <= 16'd1;
      end else begin
         for (int i = 0; i < NumCables; i++) begin
            rxWord[i] <= (ovrCyc[i] == cyc) ? ovrWord[i] : idleWord(phase, frameNo);
         end
         phase <= phase + 2'd1;
         if (phase == 2'd3) frameNo <= frameNo + 16'd1;  // next frame
      end
      cyc <= cyc + 1;
   end

   task automatic failRun();
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
         errors++;
         failRun();
      end
   endtask

   task automatic nextCycle();
      @(posedge clk);
      @(negedge clk);  // outputs settled mid cycle
   endtask

   task automatic doReset();
      @(posedge clk);
      rst <= 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      nextCycle();
   endtask

   task automatic busWrite(input busAddr_t a, input busData_t d);
      @(posedge clk);
      addr   <= a;
      wrData <= d;
      wr     <= 1'b1;
      strobe <= 1'b1;
      @(posedge clk);  // write edge
      wr     <= 1'b0;
      strobe <= 1'b0;
   endtask

   task automatic busRead(input busAddr_t a, output busData_t d);
      @(posedge clk);
      addr   <= a;
      wr     <= 1'b0;
      strobe <= 1'b0;
      @(negedge clk);
      d = rdData;  // combinational readback
   endtask

   // every cable but skip must step through the idle rotation, skip holds skipSym
   task automatic trackIdles(input int skip, input int cycles, input txSym_t skipSym);
      txSym_t prev [NumCables];
      for (int n = 0; n < cycles; n++) begin
         nextCycle();
         for (int i = 0; i < NumCables; i++) begin
            if (i == skip) begin
               check($sformatf("txSym[%0d]", i), txSym[i], skipSym);
            end else if (n == 0) begin
               check($sformatf("idle on txSym[%0d]", i), successor(txSym[i]) != 0, 1);
            end else begin
               check($sformatf("txSym[%0d]", i), txSym[i], successor(prev[i]));
            end
            prev[i] = txSym[i];
         end
      end
   endtask

   task automatic registerAccess();
      busData_t val;
      busData_t scratchVal;
      scratchVal = busData_t'($random(seed));
      busRead(AddrId, val);
      check("rdData id", val, 16'h1234);
      busWrite(AddrScratch, scratchVal);
      busRead(AddrScratch, val);
      check("rdData scratch", val, scratchVal);
      busRead(16'h0007, val);  // unmapped
      check("rdData addr 7", val, 0);
      for (int i = 0; i < NumCables; i++) begin
         busRead(AddrBadIdleBase + busAddr_t'(i), val);
         check($sformatf("badIdle[%0d]", i), val, 0);
      end
   endtask

   task automatic patternOverride();
      logic found;
      busWrite(AddrTestPatt, 16'h000a);
      busWrite(AddrTestEn, 16'h0004);  // cable 2 only
      found = 1'b0;
      for (int n = 0; n < 10 && !found; n++) begin
         nextCycle();
         found = txSym[2] == 4'b1010;
      end
      if (!found) begin
         $display("timeout waiting for the test pattern on cable 2");
         failRun();
      end
      trackIdles(2, 8, 4'b1010);
      busWrite(AddrTestEn, 16'h0000);
      found = 1'b0;
      for (int n = 0; n < 10 && !found; n++) begin
         nextCycle();
         found = successor(txSym[2]) != 0;
      end
      if (!found) begin
         $display("timeout waiting for cable 2 to return to idles");
         failRun();
      end
      trackIdles(-1, 4, 4'b0000);
   endtask

   task automatic coincidencePairs();
      int c;
      @(posedge clk);
      c = cyc;
      ovrCyc[0]        <= c + 1;  // A0 sampled two edges from here
      ovrWord[0]       <= 8'h80;
      ovrCyc[NumPairs] <= c + 2;  // B0 one edge after A0
      ovrWord[NumPairs] <= 8'h80;
      ovrCyc[1]        <= c + 1;  // A1 with no partner
      ovrWord[1]       <= 8'h81;
      for (int n = 1; n <= 10; n++) begin
         nextCycle();
         if (n == 6) begin  // trigger edge plus 4
            check("txSym[0]", txSym[0], SymPromptCoinc);
            check("txSym[1]", txSym[1], SymNoCoinc);
         end
         if (n == 7) begin
            check("txSym[4]", txSym[4], SymPromptCoinc);
            check("prompt held on txSym[0]", txSym[0] == SymPromptCoinc, 0);
         end
         check("answer on txSym[5]", (txSym[5] == SymPromptCoinc) || (txSym[5] == SymNoCoinc), 0);
      end
   endtask

   task automatic specialSequence();
      busData_t word;
      word = 16'ha5c3;
      busWrite(AddrSpecial, word);
      repeat (2) @(posedge clk);
      @(negedge clk);
      for (int i = 0; i < NumCables; i++) check($sformatf("txSym[%0d]", i), txSym[i], 4'b1100);
      for (int k = 0; k < 4; k++) begin
         nextCycle();
         for (int i = 0; i < NumCables; i++) begin
            check($sformatf("txSym[%0d]", i), txSym[i], word[15-4*k -: 4]);  // msb nibble first
         end
      end
   endtask

   task automatic badIdleCount();
      busData_t val;
      int       m;
      logic     seen;
      doReset();
      repeat (8) nextCycle();  // two clean frames
      for (int i = 0; i < NumCables; i++) begin
         busRead(AddrBadIdleBase + busAddr_t'(i), val);
         check($sformatf("badIdle[%0d]", i), val, 0);
      end
      @(posedge clk);
      m = (5 - int'(phase)) % 4;  // edges until an IDLE1 word goes out
      if (m == 0) m = 4;
      ovrCyc[3]  <= cyc + m;
      ovrWord[3] <= 8'h48;  // IDLE2 code where IDLE1 belongs
      seen = 1'b0;
      for (int n = 0; n < 20 && !seen; n++) begin
         busRead(AddrBadIdleBase + 16'd3, val);
         seen = val != 0;
      end
      if (!seen) begin
         $display("timeout waiting for the bad idle count of cable 3 to rise");
         failRun();
      end
      for (int i = 0; i < NumCables; i++) begin
         if (i != 3) begin
            busRead(AddrBadIdleBase + busAddr_t'(i), val);
            check($sformatf("badIdle[%0d]", i), val, 0);
         end
      end
   endtask

   initial begin
      rst    = 1'b1;
      addr   = '0;
      wrData = '0;
      wr     = 1'b0;
      strobe = 1'b0;
      for (int i = 0; i < NumCables; i++) begin
         ovrCyc[i]  = -1;  // no override pending
         ovrWord[i] = '0;
      end
      doReset();
      registerAccess();
      trackIdles(-1, 4, 4'b0000);
      patternOverride();
      coincidencePairs();
      specialSequence();
      badIdleCount();
      if (errors == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("SIMULATION FAILED");
         $fatal(1, "checks failed");
      end
   end

endmodule

// ==== mcuPkg.sv ====
// master coincidence unit shared widths, cable codes, register map and transmitter states
package mcuPkg;

   // widths that carry a meaning
   typedef logic [7:0]  rxWord_t;     // word arriving from a readout cable
   typedef logic [3:0]  txSym_t;      // symbol going back down a cable
   typedef logic [15:0] busAddr_t;    // register bus address
   typedef logic [15:0] busData_t;    // register bus data
   typedef logic [15:0] errCount_t;   // bad idle count per cable
   typedef logic [15:0] idleCount_t;  // frame counter carried by the idle words

   // receive side word classes
   localparam rxWord_t TrigMask = 8'b1000_0000;  // set on every trigger word
   localparam rxWord_t IdleMask = 8'b1100_1100;  // keeps the idle type bits only

   // idle word types after masking
   // each idle word also carries 4 counter bits in word bits 5:4 and 1:0
   localparam rxWord_t RxIdle0 = 8'b0100_0000;  // counter bits 3:0
   localparam rxWord_t RxIdle1 = 8'b0100_0100;  // counter bits 7:4
   localparam rxWord_t RxIdle2 = 8'b0100_1000;  // counter bits 11:8
   localparam rxWord_t RxIdle3 = 8'b0100_1100;  // counter bits 15:12, closes the frame

   // transmit symbols
   localparam txSym_t SymIdle0       = 4'b0111;
   localparam txSym_t SymIdle1       = 4'b1011;
   localparam txSym_t SymIdle2       = 4'b1101;
   localparam txSym_t SymIdle3       = 4'b1110;
   localparam txSym_t SymNoCoinc     = 4'b1001;  // no partner in the window
   localparam txSym_t SymPromptCoinc = 4'b0011;  // partner within one clock
   localparam txSym_t SymSpecial     = 4'b1100;  // header ahead of four nibbles

   // register map
   localparam busAddr_t AddrId          = 16'h0000;  // read only
   localparam busAddr_t AddrScratch     = 16'h0001;
   localparam busAddr_t AddrSpecial     = 16'h0002;  // write also launches the word
   localparam busAddr_t AddrTestPatt    = 16'h0003;
   localparam busAddr_t AddrTestEn      = 16'h0004;  // one bit per cable
   localparam busAddr_t AddrBadIdleBase = 16'h0010;  // cable i at base plus i

   localparam busData_t IdValue = 16'h1234;

   // transmitter states
   typedef enum logic [3:0] {
      Idle0,
      Idle1,
      Idle2,
      Idle3,
      NoCoinc,
      PromptCoinc,
      SpecialHdr,
      Spec1,       // nibble 15:12
      Spec2,       // nibble 11:8
      Spec3,       // nibble 7:4
      Spec4        // nibble 3:0
   } txState_e;

endpackage

// ==== regBank.sv ====
// register bank for the coincidence unit with write decode, special word pulse and readback
`timescale 1ns/10ps

module regBank #(
   parameter int NumPairs = 4
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  mcuPkg::busAddr_t                     addr,
   input  mcuPkg::busData_t                     wrData,
   input  logic                                 wr,
   input  logic                                 strobe,
   output mcuPkg::busData_t                     rdData,
   input  mcuPkg::errCount_t [2*NumPairs-1:0]   badIdle,      // per cable counters
   output mcuPkg::busData_t                     specialWord,
   output mcuPkg::txSym_t                       testPatt,
   output logic              [2*NumPairs-1:0]   testEn,       // bit i drives cable i
   output logic                                 specialGo     // one cycle after the write
);
   import mcuPkg::*;

   localparam int NumCables = 2 * NumPairs;  // A side first, then B side

   busData_t scratch;  // free read/write word for bus checks
   logic     wrEn;     // qualified write strobe

   // a write needs both wr and strobe
   assign wrEn = wr && strobe;

   always_ff @(posedge clk) begin
      if (rst) begin
         scratch     <= '0;
         specialWord <= '0;
         testPatt    <= '0;
         testEn      <= '0;
         specialGo   <= 1'b0;
      end else begin
         // transmitters start the special sequence from this pulse
         specialGo <= wrEn && (addr == AddrSpecial);
         if (wrEn) begin
            case (addr)
               AddrScratch:  scratch     <= wrData;
               AddrSpecial:  specialWord <= wrData;
               AddrTestPatt: testPatt    <= wrData[$bits(txSym_t)-1:0];
               AddrTestEn:   testEn      <= wrData[NumCables-1:0];
               default: ;  // id and counters are read only
            endcase
         end
      end
   end

   // readback mux
   // unmapped addresses read as zero
   always_comb begin
      rdData = '0;
      case (addr)
         AddrId:       rdData = IdValue;
         AddrScratch:  rdData = scratch;
         AddrSpecial:  rdData = specialWord;
         AddrTestPatt: rdData[$bits(txSym_t)-1:0] = testPatt;  // upper bits stay zero
         AddrTestEn:   rdData[NumCables-1:0] = testEn;
         default: begin
            // bad idle counters, one address per cable
            for (int i = 0; i < NumCables; i++) begin
               if (addr == AddrBadIdleBase + busAddr_t'(i)) begin
                  rdData = badIdle[i];
               end
            end
         end
      endcase
   end

endmodule
